/* Bender.yml */
package:
  name: gps_channel

sources:
  - gps_pkg.sv
  - seek_if.sv
  - code_gen.sv
  - correlator.sv
  - power_unit.sv
  - acq_search.sv
  - channel_top.sv
  - target: test
    files:
      - tb_clock.sv
      - channel_properties.sv
      - channel_tb.sv

/* acq_search.sv */
`timescale 1ns/10ps

module acq_search #(
   parameter int ACQ_SPAN = 8
) (
   input  logic                      clk,
   input  logic                      i_rst,
   input  gps_pkg::mode_e            i_mode,
   input  logic                      i_acq_start,
   input  logic                      i_power_valid,
   input  logic [gps_pkg::POW_W-1:0] i_pow_p,
   seek_if.requester                 seek,
   output logic                      o_acq_done,
   output logic [gps_pkg::POW_W-1:0] o_peak_pow,
   output logic [gps_pkg::CS_W-1:0]  o_peak_shift
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_SEEK,
      S_INTEGRATE,
      S_COMPARE,
      S_DONE
   } state_e;

   state_e               state;
   gps_pkg::mode_e       mode_q;
   logic                 start;

   // Entering acquisition mode starts a sweep.
   assign start = i_acq_start ||
                  (i_mode == gps_pkg::MODE_ACQ && mode_q != gps_pkg::MODE_ACQ);

   always_ff @(posedge clk) begin
      if (i_rst) begin
         state            <= S_IDLE;
         mode_q           <= gps_pkg::MODE_TRACK;
         seek.seek_en     <= 1'b0;
         seek.seek_target <= '0;
         o_acq_done       <= 1'b0;
         o_peak_pow       <= '0;
         o_peak_shift     <= '0;
      end else begin
         mode_q     <= i_mode;
         o_acq_done <= 1'b0;
         if (start) begin
            state            <= S_SEEK;
            seek.seek_en     <= 1'b0;
            seek.seek_target <= '0;
            o_peak_pow       <= '0;
            o_peak_shift     <= '0;
         end else begin
            case (state)
               S_SEEK: begin
                  seek.seek_en <= 1'b1;
                  if (seek.target_reached) begin
                     seek.seek_en <= 1'b0;
                     state        <= S_INTEGRATE;
                  end
               end
               S_INTEGRATE:
                  if (i_power_valid)
                     state <= S_COMPARE;
               S_COMPARE: begin
                  // Strict compare keeps the first shift on a tie.
                  if (i_pow_p > o_peak_pow) begin
                     o_peak_pow   <= i_pow_p;
                     o_peak_shift <= seek.seek_target;
                  end
                  if (seek.seek_target == gps_pkg::CS_W'(ACQ_SPAN - 1)) begin
                     state <= S_DONE;
                  end else begin
                     seek.seek_target <= seek.seek_target + 1'b1;
                     state            <= S_SEEK;
                  end
               end
               S_DONE: begin
                  o_acq_done <= 1'b1;
                  state      <= S_IDLE;
               end
               default: state <= S_IDLE;
            endcase
         end
      end
   end

endmodule

/* channel_properties.sv */
`timescale 1ns/10ps

module channel_properties (
   input logic clk,
   input logic i_rst,
   input logic i_req,
   input logic i_ack,
   input logic i_seeking,
   input logic i_busy,
   input logic i_acc_done,
   input logic i_valid
);

   int n_fail = 0;

   // Ack is only ever a reply to req.
   a_ack_follows_req: assert property (
      @(posedge clk) disable iff (i_rst) i_ack |-> $past(i_req)
   ) else begin
      $error("sample ack high without a request in the previous cycle");
      n_fail++;
   end

   a_ack_blocked: assert property (
      @(posedge clk) disable iff (i_rst) $rose(i_ack) |-> $past(!i_seeking && !i_busy)
   ) else begin
      $error("sample ack rose while seeking or while the power unit was busy");
      n_fail++;
   end

   // Power result lands exactly eight cycles after the integration ends.
   a_valid_latency: assert property (
      @(posedge clk) disable iff (i_rst) i_acc_done |=> (!i_valid) [*7] ##1 i_valid
   ) else begin
      $error("power valid not exactly eight cycles after accumulation done");
      n_fail++;
   end

endmodule

bind channel_top channel_properties u_props (
   .clk        (clk),
   .i_rst      (i_rst),
   .i_req      (i_sample_req),
   .i_ack      (o_sample_ack),
   .i_seeking  (o_seeking),
   .i_busy     (busy),
   .i_acc_done (acc_done),
   .i_valid    (o_power_valid)
);

/* channel_tb.sv */
`timescale 1ns/10ps

module channel_tb;

   localparam int INT_LEN  = 16;
   localparam int ACQ_SPAN = 8;
   localparam int TIMEOUT  = 2000;
   localparam int N_TESTS  = 7;

   localparam int PAT_CONST = 0;
   localparam int PAT_RAND  = 1;
   localparam int PAT_REP   = 2;

   localparam int W_ACK     = 0;
   localparam int W_SEEKING = 1;
   localparam int W_VALID   = 2;
   localparam int W_ACQ     = 3;
   localparam int W_RST     = 4;

   logic                                clk;
   logic                                rst;
   gps_pkg::mode_e                      mode;
   logic [2:0]                          prn;
   logic                                sample_req;
   logic signed [gps_pkg::SAMPLE_W-1:0] sample_i;
   logic signed [gps_pkg::SAMPLE_W-1:0] sample_q;
   logic                                sample_ack;
   logic                                seek_en;
   logic [gps_pkg::CS_W-1:0]            seek_target;
   logic                                seeking;
   logic                                acq_start;
   logic                                power_valid;
   logic [gps_pkg::POW_W-1:0]           pow_e;
   logic [gps_pkg::POW_W-1:0]           pow_p;
   logic [gps_pkg::POW_W-1:0]           pow_l;
   logic [gps_pkg::CS_W-1:0]            code_shift;
   logic                                acq_done;
   logic [gps_pkg::POW_W-1:0]           peak_pow;
   logic [gps_pkg::CS_W-1:0]            peak_shift;

   // One test per table row.
   int     t_acq [0:N_TESTS-1];
   int     t_prn [0:N_TESTS-1];
   int     t_target [0:N_TESTS-1];
   int     t_pat [0:N_TESTS-1];
   int     t_rep [0:N_TESTS-1];
   int     t_ai [0:N_TESTS-1];
   int     t_aq [0:N_TESTS-1];
   int     t_hold [0:N_TESTS-1];
   int     t_differ [0:N_TESTS-1];
   int     t_exp [0:N_TESTS-1];
   string  t_name [0:N_TESTS-1];
   int     n_rows;

   int     smp_i [0:2*INT_LEN-1];
   int     smp_q [0:2*INT_LEN-1];
   longint pow_p_seen [0:N_TESTS-1];
   int     valid_cnt;
   int     acq_cnt;
   int     cnt_at_ack;
   int     errors;
   int     test_errs;
   int     checks;
   int     aborted;
   int     seed_val;
   int     idx;

   tb_clock #(.HALF_PERIOD(5), .RST_CYCLES(5)) u_clock (
      .o_clk (clk),
      .o_rst (rst)
   );

   channel_top #(.INT_LEN(INT_LEN), .ACQ_SPAN(ACQ_SPAN)) uut (
      .clk           (clk),
      .i_rst         (rst),
      .i_mode        (mode),
      .i_prn         (prn),
      .i_sample_req  (sample_req),
      .i_sample_i    (sample_i),
      .i_sample_q    (sample_q),
      .o_sample_ack  (sample_ack),
      .i_seek_en     (seek_en),
      .i_seek_target (seek_target),
      .o_seeking     (seeking),
      .i_acq_start   (acq_start),
      .o_power_valid (power_valid),
      .o_pow_e       (pow_e),
      .o_pow_p       (pow_p),
      .o_pow_l       (pow_l),
      .o_code_shift  (code_shift),
      .o_acq_done    (acq_done),
      .o_peak_pow    (peak_pow),
      .o_peak_shift  (peak_shift)
   );

   // Count pulses so no single-cycle strobe is missed.
   always @(posedge clk) begin
      if (power_valid === 1'b1)
         valid_cnt <= valid_cnt + 1;
      if (acq_done === 1'b1)
         acq_cnt <= acq_cnt + 1;
   end

   // C/A Gold code chip n counted from the all-ones state.
   function automatic logic gold_chip(input int prn_idx, input int n);
      logic [10:1] g1;
      logic [10:1] g2;
      logic        f1;
      logic        f2;
      int          s;
      g1 = '1;
      g2 = '1;
      for (s = 0; s < n; s++) begin
         f1 = g1[3] ^ g1[10];
         f2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
         g1 = {g1[9:1], f1};
         g2 = {g2[9:1], f2};
      end
      return g1[10] ^ g2[gps_pkg::g2_taps[prn_idx][0]] ^ g2[gps_pkg::g2_taps[prn_idx][1]];
   endfunction

   function automatic int probe(input int which);
      case (which)
         W_ACK:     return int'(sample_ack);
         W_SEEKING: return int'(seeking);
         W_VALID:   return valid_cnt;
         W_ACQ:     return acq_cnt;
         default:   return int'(rst);
      endcase
   endfunction

   task automatic add_row(input int acq, input int prn_idx, input int target, input int pat,
                          input int rep, input int ai, input int aq, input int hold,
                          input int differ, input int exp_val, input string name);
      t_acq[n_rows]    = acq;
      t_prn[n_rows]    = prn_idx;
      t_target[n_rows] = target;
      t_pat[n_rows]    = pat;
      t_rep[n_rows]    = rep;
      t_ai[n_rows]     = ai;
      t_aq[n_rows]     = aq;
      t_hold[n_rows]   = hold;
      t_differ[n_rows] = differ;
      t_exp[n_rows]    = exp_val;
      t_name[n_rows]   = name;
      n_rows++;
   endtask

   task automatic check_val(input string name, input longint got, input longint exp_val);
      checks++;
      if (got !== exp_val) begin
         $display("error at %0t: %s got %0d expected %0d", $time, name, got, exp_val);
         errors++;
         test_errs++;
      end
   endtask

   task automatic wait_until(input int which, input int value, input string what);
      int n;
      n = 0;
      if (aborted == 0) begin
         while (probe(which) != value && n < TIMEOUT) begin
            @(negedge clk);
            n++;
         end
         if (probe(which) != value) begin
            $display("timeout at %0t: %s did not happen within %0d cycles",
                     $time, what, TIMEOUT);
            errors++;
            test_errs++;
            aborted = 1;
         end
      end
   endtask

   task automatic send_sample(input int si, input int sq);
      sample_i   = si[3:0];
      sample_q   = sq[3:0];
      sample_req = 1'b1;
      wait_until(W_ACK, 1, "sample ack rise");
      cnt_at_ack = valid_cnt;
      sample_req = 1'b0;
      wait_until(W_ACK, 0, "sample ack fall");
   endtask

   task automatic send_block(input int first, input int count);
      int k;
      for (k = first; k < first + count; k++)
         send_sample(smp_i[k], smp_q[k]);
   endtask

   task automatic do_seek(input int target);
      seek_target = target[9:0];
      seek_en     = 1'b1;
      wait_until(W_SEEKING, 1, "seek start");
      wait_until(W_SEEKING, 0, "seek end");
      seek_en = 1'b0;
      check_val("o_code_shift", code_shift, target);
   endtask

   // Correlate samples base.. against chips that start at code phase t.
   task automatic model_powers(input int prn_idx, input int t, input int base,
                               output longint pe, output longint pp, output longint pl);
      longint ei, eq, ppi, ppq, li, lq;
      int     k;
      int     n;
      logic   ce;
      logic   cp;
      logic   cl;
      ei  = 0;
      eq  = 0;
      ppi = 0;
      ppq = 0;
      li  = 0;
      lq  = 0;
      for (k = base; k < base + INT_LEN; k++) begin
         n  = t + k;
         ce = gold_chip(prn_idx, n + 1);
         cp = gold_chip(prn_idx, n);
         cl = (n == 0) ? 1'b0 : gold_chip(prn_idx, n - 1);
         ei  += ce ? smp_i[k] : -smp_i[k];
         eq  += ce ? smp_q[k] : -smp_q[k];
         ppi += cp ? smp_i[k] : -smp_i[k];
         ppq += cp ? smp_q[k] : -smp_q[k];
         li  += cl ? smp_i[k] : -smp_i[k];
         lq  += cl ? smp_q[k] : -smp_q[k];
      end
      pe = ei * ei + eq * eq;
      pp = ppi * ppi + ppq * ppq;
      pl = li * li + lq * lq;
   endtask

   task automatic check_powers(input int row, input int base);
      longint pe, pp, pl;
      model_powers(t_prn[row], t_target[row], base, pe, pp, pl);
      check_val("o_pow_e", pow_e, pe);
      check_val("o_pow_p", pow_p, pp);
      check_val("o_pow_l", pow_l, pl);
      if (t_pat[row] == PAT_REP && t_rep[row] == t_prn[row]) begin
         check_val("o_pow_p", pow_p,
                   INT_LEN * INT_LEN * (t_ai[row] * t_ai[row] + t_aq[row] * t_aq[row]));
         check_val("o_pow_e below o_pow_p", pow_e < pow_p, 1);
         check_val("o_pow_l below o_pow_p", pow_l < pow_p, 1);
      end
   endtask

   task automatic run_test(input int row);
      int     k, j, r, vbase, abase, best_shift;
      longint pe, pp, pl, best_pow;
      logic   chip;
      test_errs = 0;
      prn = t_prn[row][2:0];
      for (k = 0; k < 2 * INT_LEN; k++) begin
         if (t_pat[row] == PAT_RAND) begin
            r = $urandom_range(15, 0);
            smp_i[k] = r - 8;
            r = $urandom_range(15, 0);
            smp_q[k] = r - 8;
         end else if (t_pat[row] == PAT_REP) begin
            chip = gold_chip(t_rep[row], t_target[row] + k);
            smp_i[k] = chip ? t_ai[row] : -t_ai[row];
            smp_q[k] = chip ? t_aq[row] : -t_aq[row];
         end else begin
            smp_i[k] = t_ai[row];
            smp_q[k] = t_aq[row];
         end
      end
      vbase = valid_cnt;
      if (t_acq[row] != 0) begin
         abase      = acq_cnt;
         best_pow   = 0;
         best_shift = 0;
         mode       = gps_pkg::MODE_ACQ;
         for (j = 0; j < ACQ_SPAN; j++) begin
            wait_until(W_SEEKING, 1, "acquisition seek start");
            wait_until(W_SEEKING, 0, "acquisition seek end");
            send_block(0, INT_LEN);
            wait_until(W_VALID, vbase + j + 1, "power valid in acquisition");
            model_powers(t_prn[row], j, 0, pe, pp, pl);
            check_val("o_pow_p", pow_p, pp);
            // First shift wins on a tie.
            if (pp > best_pow) begin
               best_pow   = pp;
               best_shift = j;
            end
         end
         wait_until(W_ACQ, abase + 1, "acquisition done");
         check_val("o_peak_pow", peak_pow, best_pow);
         check_val("o_peak_shift", peak_shift, best_shift);
         check_val("o_peak_shift", peak_shift, t_exp[row]);
         mode = gps_pkg::MODE_TRACK;
      end else begin
         mode = gps_pkg::MODE_TRACK;
         do_seek(t_target[row]);
         send_block(0, INT_LEN);
         if (t_hold[row] != 0) begin
            // This request arrives while the powers are being squared.
            send_sample(smp_i[INT_LEN], smp_q[INT_LEN]);
            check_val("power valid count at held ack", cnt_at_ack, vbase + 1);
         end else begin
            wait_until(W_VALID, vbase + 1, "power valid");
         end
         check_powers(row, 0);
         if (t_hold[row] != 0) begin
            send_block(INT_LEN + 1, INT_LEN - 1);
            wait_until(W_VALID, vbase + 2, "second power valid");
            check_powers(row, INT_LEN);
         end
         check_val("o_code_shift", code_shift, t_exp[row]);
      end
      pow_p_seen[row] = pow_p;
      if (t_differ[row] != 0)
         check_val("o_pow_p differs from previous prn", pow_p != pow_p_seen[row - 1], 1);
      $display("test %0d %s: %0d errors", row, t_name[row], test_errs);
   endtask

   initial begin
      seed_val    = $urandom(10);
      mode        = gps_pkg::MODE_TRACK;
      prn         = 3'd0;
      sample_req  = 1'b0;
      sample_i    = '0;
      sample_q    = '0;
      seek_en     = 1'b0;
      seek_target = '0;
      acq_start   = 1'b0;
      valid_cnt   = 0;
      acq_cnt     = 0;
      errors      = 0;
      checks      = 0;
      aborted     = 0;
      n_rows      = 0;

      // acq, prn index, target, pattern, replica prn, amp i, amp q, hold, differ, expected shift
      add_row(0, 0,   5, PAT_CONST, 0, 2,  1, 0, 0,  21, "seek then constant samples");
      add_row(0, 2, 100, PAT_RAND,  0, 0,  0, 0, 0, 116, "random samples");
      add_row(0, 1,  37, PAT_REP,   1, 3, -2, 0, 0,  53, "prompt replica");
      add_row(1, 1,   3, PAT_REP,   1, 3, -2, 0, 0,   3, "acquisition sweep");
      add_row(0, 3, 200, PAT_RAND,  0, 0,  0, 1, 0, 232, "request held during power");
      add_row(0, 0,  10, PAT_REP,   0, 3, -2, 0, 0,  26, "replica on prn 1");
      add_row(0, 4,  10, PAT_REP,   0, 3, -2, 0, 1,  26, "same replica on prn 5");

      @(negedge clk);
      wait_until(W_RST, 0, "reset release");
      test_errs = 0;
      check_val("o_sample_ack", sample_ack, 0);
      check_val("o_power_valid", power_valid, 0);
      check_val("o_acq_done", acq_done, 0);
      check_val("o_seeking", seeking, 0);

      for (idx = 0; idx < n_rows; idx++) begin
         if (aborted == 0)
            run_test(idx);
      end

      errors = errors + uut.u_props.n_fail;
      $display("%0d tests, %0d checks, %0d errors", n_rows, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

/* channel_top.sv */
`timescale 1ns/10ps

module channel_top #(
   parameter int INT_LEN  = 16,
   parameter int ACQ_SPAN = 8
) (
   input  logic                                clk,
   input  logic                                i_rst,
   input  gps_pkg::mode_e                      i_mode,
   input  logic [2:0]                          i_prn,
   input  logic                                i_sample_req,
   input  logic signed [gps_pkg::SAMPLE_W-1:0] i_sample_i,
   input  logic signed [gps_pkg::SAMPLE_W-1:0] i_sample_q,
   output logic                                o_sample_ack,
   input  logic                                i_seek_en,
   input  logic [gps_pkg::CS_W-1:0]            i_seek_target,
   output logic                                o_seeking,
   input  logic                                i_acq_start,
   output logic                                o_power_valid,
   output logic [gps_pkg::POW_W-1:0]           o_pow_e,
   output logic [gps_pkg::POW_W-1:0]           o_pow_p,
   output logic [gps_pkg::POW_W-1:0]           o_pow_l,
   output logic [gps_pkg::CS_W-1:0]            o_code_shift,
   output logic                                o_acq_done,
   output logic [gps_pkg::POW_W-1:0]           o_peak_pow,
   output logic [gps_pkg::CS_W-1:0]            o_peak_shift
);

   seek_if acq_sk ();
   seek_if cg_sk ();

   logic          acq_mode;
   logic          consume;
   logic          accept_ok;
   logic          chip_e;
   logic          chip_p;
   logic          chip_l;
   logic          acc_done;
   logic          busy;
   gps_pkg::acc_t acc;

   // Seek request comes from the host in track mode.
   assign acq_mode              = (i_mode == gps_pkg::MODE_ACQ);
   assign cg_sk.seek_en         = acq_mode ? acq_sk.seek_en : i_seek_en;
   assign cg_sk.seek_target     = acq_mode ? acq_sk.seek_target : i_seek_target;
   assign acq_sk.seeking        = acq_mode && cg_sk.seeking;
   assign acq_sk.target_reached = acq_mode && cg_sk.target_reached;
   assign o_seeking             = cg_sk.seeking;

   // Back-pressure while seeking, squaring or before the accumulator clear.
   assign accept_ok = !cg_sk.seeking && !busy && !acc_done;
   assign consume   = i_sample_req && !o_sample_ack && accept_ok;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_sample_ack <= 1'b0;
      end else begin
         o_sample_ack <= i_sample_req && (o_sample_ack || accept_ok);
      end
   end

   code_gen u_code_gen (
      .clk          (clk),
      .i_rst        (i_rst),
      .i_prn        (i_prn),
      .i_step       (consume),
      .seek         (cg_sk.target),
      .o_chip_e     (chip_e),
      .o_chip_p     (chip_p),
      .o_chip_l     (chip_l),
      .o_code_shift (o_code_shift)
   );

   correlator #(.INT_LEN(INT_LEN)) u_correlator (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_consume  (consume),
      .i_sample_i (i_sample_i),
      .i_sample_q (i_sample_q),
      .i_chip_e   (chip_e),
      .i_chip_p   (chip_p),
      .i_chip_l   (chip_l),
      .o_acc      (acc),
      .o_acc_done (acc_done)
   );

   power_unit u_power_unit (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_acc_done    (acc_done),
      .i_acc         (acc),
      .o_busy        (busy),
      .o_power_valid (o_power_valid),
      .o_pow_e       (o_pow_e),
      .o_pow_p       (o_pow_p),
      .o_pow_l       (o_pow_l)
   );

   acq_search #(.ACQ_SPAN(ACQ_SPAN)) u_acq_search (
      .clk           (clk),
      .i_rst         (i_rst),
      .i_mode        (i_mode),
      .i_acq_start   (i_acq_start),
      .i_power_valid (o_power_valid),
      .i_pow_p       (o_pow_p),
      .seek          (acq_sk.requester),
      .o_acq_done    (o_acq_done),
      .o_peak_pow    (o_peak_pow),
      .o_peak_shift  (o_peak_shift)
   );

endmodule

/* code_gen.sv */
`timescale 1ns/10ps

module code_gen (
   input  logic                     clk,
   input  logic                     i_rst,
   input  logic [2:0]               i_prn,
   input  logic                     i_step,
   seek_if.target                   seek,
   output logic                     o_chip_e,
   output logic                     o_chip_p,
   output logic                     o_chip_l,
   output logic [gps_pkg::CS_W-1:0] o_code_shift
);

   logic [10:1]               g1;
   logic [10:1]               g2;
   logic                      gen_chip;
   logic                      chip_p;
   logic                      chip_l;
   logic [gps_pkg::CS_W-1:0]  remain;
   logic                      seek_done;
   logic                      seek_start;
   logic                      advance;

   // Generator sits one chip ahead of prompt, so it is the early chip.
   assign gen_chip = g1[10] ^ g2[gps_pkg::g2_taps[i_prn][0]] ^ g2[gps_pkg::g2_taps[i_prn][1]];

   assign seek_start = seek.seek_en && !seek.seeking && !seek_done;
   assign advance    = seek.seeking || i_step;

   always_ff @(posedge clk) begin
      if (i_rst) begin
         g1                  <= '0;
         g2                  <= '0;
         chip_p              <= 1'b0;
         chip_l              <= 1'b0;
         remain              <= '0;
         seek_done           <= 1'b0;
         seek.seeking        <= 1'b0;
         seek.target_reached <= 1'b0;
         o_code_shift        <= '0;
      end else begin
         seek.target_reached <= 1'b0;
         if (!seek.seek_en)
            seek_done <= 1'b0;
         if (seek_start) begin
            // Reload to code phase zero, then skip target+1 chips.
            g1           <= '1;
            g2           <= '1;
            chip_p       <= 1'b0;
            chip_l       <= 1'b0;
            remain       <= seek.seek_target;
            seek.seeking <= 1'b1;
         end else if (advance) begin
            g1     <= {g1[9:1], g1[3] ^ g1[10]};
            g2     <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
            chip_p <= gen_chip;
            chip_l <= chip_p;
            if (seek.seeking) begin
               if (remain == '0) begin
                  seek.seeking        <= 1'b0;
                  seek.target_reached <= 1'b1;
                  seek_done           <= 1'b1;
                  o_code_shift        <= seek.seek_target;
               end else begin
                  remain <= remain - 1'b1;
               end
            end else if (o_code_shift == gps_pkg::CS_W'(gps_pkg::CODE_LEN - 1)) begin
               o_code_shift <= '0;
            end else begin
               o_code_shift <= o_code_shift + 1'b1;
            end
         end
      end
   end

   assign o_chip_e = gen_chip;
   assign o_chip_p = chip_p;
   assign o_chip_l = chip_l;

endmodule

/* correlator.sv */
`timescale 1ns/10ps

module correlator #(
   parameter int INT_LEN = 16
) (
   input  logic                                clk,
   input  logic                                i_rst,
   input  logic                                i_consume,
   input  logic signed [gps_pkg::SAMPLE_W-1:0] i_sample_i,
   input  logic signed [gps_pkg::SAMPLE_W-1:0] i_sample_q,
   input  logic                                i_chip_e,
   input  logic                                i_chip_p,
   input  logic                                i_chip_l,
   output gps_pkg::acc_t                       o_acc,
   output logic                                o_acc_done
);

   localparam int CNT_W = $clog2(INT_LEN + 1);

   logic                                upd;
   logic signed [gps_pkg::SAMPLE_W-1:0] s_i;
   logic signed [gps_pkg::SAMPLE_W-1:0] s_q;
   logic                                c_e;
   logic                                c_p;
   logic                                c_l;
   logic [CNT_W-1:0]                    cnt;

   // Add on a one chip, subtract on a zero chip.
   function automatic logic signed [gps_pkg::ACC_W-1:0] mac(
      input logic signed [gps_pkg::ACC_W-1:0]    acc,
      input logic signed [gps_pkg::SAMPLE_W-1:0] s,
      input logic                                chip
   );
      logic signed [gps_pkg::ACC_W-1:0] ext;
      ext = gps_pkg::ACC_W'(s);
      return chip ? acc + ext : acc - ext;
   endfunction

   always_ff @(posedge clk) begin
      if (i_rst) begin
         upd <= 1'b0;
         s_i <= '0;
         s_q <= '0;
         c_e <= 1'b0;
         c_p <= 1'b0;
         c_l <= 1'b0;
      end else begin
         upd <= i_consume;
         if (i_consume) begin
            s_i <= i_sample_i;
            s_q <= i_sample_q;
            c_e <= i_chip_e;
            c_p <= i_chip_p;
            c_l <= i_chip_l;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_acc      <= '0;
         cnt        <= '0;
         o_acc_done <= 1'b0;
      end else begin
         o_acc_done <= 1'b0;
         if (o_acc_done) begin
            o_acc <= '0;
         end else if (upd) begin
            o_acc.e_i <= mac(o_acc.e_i, s_i, c_e);
            o_acc.e_q <= mac(o_acc.e_q, s_q, c_e);
            o_acc.p_i <= mac(o_acc.p_i, s_i, c_p);
            o_acc.p_q <= mac(o_acc.p_q, s_q, c_p);
            o_acc.l_i <= mac(o_acc.l_i, s_i, c_l);
            o_acc.l_q <= mac(o_acc.l_q, s_q, c_l);
            if (cnt == CNT_W'(INT_LEN - 1)) begin
               cnt        <= '0;
               o_acc_done <= 1'b1;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      end
   end

endmodule

/* gps_pkg.sv */
package gps_pkg;

   // Sample, accumulator, power and code shift widths.
   localparam int SAMPLE_W = 4;
   localparam int ACC_W    = 16;
   localparam int POW_W    = 32;
   localparam int CS_W     = 10;

   // Chips per C/A code period.
   localparam int CODE_LEN = 1023;

   typedef enum logic {
      MODE_TRACK = 1'b0,
      MODE_ACQ   = 1'b1
   } mode_e;

   // G2 phase selector taps, 1-based stage numbers.
   // Row index is the PRN minus one.
   localparam int g2_taps [0:7][0:1] = '{
      '{2, 6},
      '{3, 7},
      '{4, 8},
      '{5, 9},
      '{1, 9},
      '{2, 10},
      '{1, 8},
      '{2, 9}
   };

   // One full set of early, prompt and late accumulations.
   typedef struct packed {
      logic signed [ACC_W-1:0] e_i;
      logic signed [ACC_W-1:0] e_q;
      logic signed [ACC_W-1:0] p_i;
      logic signed [ACC_W-1:0] p_q;
      logic signed [ACC_W-1:0] l_i;
      logic signed [ACC_W-1:0] l_q;
   } acc_t;

endpackage

/* power_unit.sv */
`timescale 1ns/10ps

module power_unit (
   input  logic                      clk,
   input  logic                      i_rst,
   input  logic                      i_acc_done,
   input  gps_pkg::acc_t             i_acc,
   output logic                      o_busy,
   output logic                      o_power_valid,
   output logic [gps_pkg::POW_W-1:0] o_pow_e,
   output logic [gps_pkg::POW_W-1:0] o_pow_p,
   output logic [gps_pkg::POW_W-1:0] o_pow_l
);

   localparam int MAG_W = gps_pkg::ACC_W;

   logic [MAG_W-1:0]          mag [0:5];
   logic [2:0]                cnt;
   logic [1:0]                sel;
   logic                      issue;
   logic [MAG_W-1:0]          mux_i;
   logic [MAG_W-1:0]          mux_q;
   logic [gps_pkg::POW_W-1:0] sq_i;
   logic [gps_pkg::POW_W-1:0] sq_q;
   logic [gps_pkg::POW_W-1:0] sum;
   logic                      st1_v;
   logic                      st2_v;
   logic [1:0]                st1_sel;
   logic [1:0]                st2_sel;

   function automatic logic [MAG_W-1:0] mag_of(input logic signed [MAG_W-1:0] v);
      return v[MAG_W-1] ? MAG_W'(-v) : MAG_W'(v);
   endfunction

   // One square issued every other cycle.
   assign issue = o_busy && cnt[0] && (sel != 2'd3);

   assign mux_i = (sel == 2'd0) ? mag[0] : (sel == 2'd1) ? mag[2] : mag[4];
   assign mux_q = (sel == 2'd0) ? mag[1] : (sel == 2'd1) ? mag[3] : mag[5];

   always_ff @(posedge clk) begin
      if (i_rst) begin
         for (int k = 0; k < 6; k++)
            mag[k] <= '0;
         sq_i <= '0;
         sq_q <= '0;
         sum  <= '0;
      end else begin
         if (i_acc_done) begin
            mag[0] <= mag_of(i_acc.e_i);
            mag[1] <= mag_of(i_acc.e_q);
            mag[2] <= mag_of(i_acc.p_i);
            mag[3] <= mag_of(i_acc.p_q);
            mag[4] <= mag_of(i_acc.l_i);
            mag[5] <= mag_of(i_acc.l_q);
         end
         sq_i <= mux_i * mux_i;
         sq_q <= mux_q * mux_q;
         sum  <= sq_i + sq_q;
      end
   end

   always_ff @(posedge clk) begin
      if (i_rst) begin
         o_busy        <= 1'b0;
         cnt           <= '0;
         sel           <= '0;
         st1_v         <= 1'b0;
         st2_v         <= 1'b0;
         st1_sel       <= '0;
         st2_sel       <= '0;
         o_power_valid <= 1'b0;
         o_pow_e       <= '0;
         o_pow_p       <= '0;
         o_pow_l       <= '0;
      end else begin
         st1_v         <= issue;
         st1_sel       <= sel;
         st2_v         <= st1_v;
         st2_sel       <= st1_sel;
         o_power_valid <= 1'b0;
         if (i_acc_done) begin
            o_busy <= 1'b1;
            cnt    <= 3'd1;
            sel    <= '0;
         end else if (o_busy) begin
            cnt <= cnt + 1'b1;
            if (issue)
               sel <= sel + 1'b1;
         end
         // Sum is two cycles behind the mux select.
         if (st2_v) begin
            case (st2_sel)
               2'd0:    o_pow_e <= sum;
               2'd1:    o_pow_p <= sum;
               default: begin
                  o_pow_l       <= sum;
                  o_power_valid <= 1'b1;
                  o_busy        <= 1'b0;
               end
            endcase
         end
      end
   end

endmodule

/* seek_if.sv */
`timescale 1ns/10ps

interface seek_if;

   logic                       seek_en;
   logic [gps_pkg::CS_W-1:0]   seek_target;
   logic                       seeking;
   logic                       target_reached;

   modport requester (
      output seek_en,
      output seek_target,
      input  seeking,
      input  target_reached
   );

   modport target (
      input  seek_en,
      input  seek_target,
      output seeking,
      output target_reached
   );

endinterface

/* sim.f */
gps_pkg.sv
seek_if.sv
code_gen.sv
correlator.sv
power_unit.sv
acq_search.sv
channel_top.sv
tb_clock.sv
channel_properties.sv
channel_tb.sv

/* tb_clock.sv */
`timescale 1ns/10ps

module tb_clock #(
   parameter int HALF_PERIOD = 5,
   parameter int RST_CYCLES  = 5
) (
   output logic o_clk,
   output logic o_rst
);

   initial begin
      o_clk = 1'b0;
      forever #(HALF_PERIOD) o_clk = ~o_clk;
   end

   // Reset covers the first RST_CYCLES rising edges.
   initial begin
      o_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge o_clk);
      o_rst <= 1'b0;
   end

endmodule
